// File: source/spi_pkg.sv
package spi_pkg;

  // byte framing on the wire
  localparam int byte_bits = 8; // msb first, spi mode 0

  // command byte, first byte after csn falls
  localparam logic [byte_bits-1:0] cmd_write = 8'h00; // host writes data bytes
  localparam logic [byte_bits-1:0] cmd_read = 8'h01;  // host clocks out dummy bytes, reads miso

  // address phase follows the command byte
  localparam int addr_bytes = 4;                     // sent msb byte first
  localparam int addr_bits = addr_bytes * byte_bits; // 32 bit byte address

  // frame layout seen by the host
  //   csn low
  //   command byte
  //   addr[31:24] addr[23:16] addr[15:8] addr[7:0]
  //   data bytes, address +1 per byte
  //   csn high ends the burst

  // other command values are ignored until csn rises

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

  // word side of the loader
  localparam int word_bits = 16;

  // memory map, decoded from the top address byte
  localparam logic [7:0] region_mem = 8'h00;  // word memory
  localparam logic [7:0] region_ctrl = 8'hFF; // cpu control register
  // any other top byte is unmapped: reads give 0, writes are dropped

  // word address taken from byte address bits [mem_addr_bits:1]
  localparam int mem_addr_bits = 10;
  localparam int mem_depth = 2 ** mem_addr_bits; // higher address bits alias

  // cycles from req to valid rdata
  localparam int read_latency = 2;

  // byte order inside a word
  //   even byte address -> word[15:8]
  //   odd byte address  -> word[7:0]
  // a word is written only when the odd byte arrives,
  // so the host should write pairs, even address first

endpackage

// File: source/spi_bus_if.sv
interface spi_bus_if;
  import spi_pkg::*;

  logic rd;                     // pulse, fetch byte at addr
  logic wr;                     // pulse, data_out valid for addr
  logic [addr_bits-1:0] addr;   // byte address, stable until next byte boundary
  logic [byte_bits-1:0] data_out; // byte received from host
  logic [byte_bits-1:0] data_in;  // byte for host, valid 3 cycles after rd

  modport slave
  (
    output rd, wr, addr, data_out,
    input data_in
  );

  modport bridge
  (
    input rd, wr, addr, data_out,
    output data_in
  );

endinterface

// File: source/mem_if.sv
interface mem_if;
  import mem_pkg::*;

  // word port standing in for the sdram cpu side
  logic req;                      // one cycle request
  logic we;                       // 1 write, 0 read, valid with req
  logic [mem_addr_bits-1:0] addr; // word address
  logic [word_bits-1:0] wdata;
  logic [word_bits-1:0] rdata;    // read_latency cycles after req, held

  modport bridge
  (
    output req, we, addr, wdata,
    input rdata
  );

  modport ram
  (
    input req, we, addr, wdata,
    output rdata
  );

  // no ready or ack, fixed latency only
  // sclk rate keeps requests far apart

endinterface

// File: source/spi_rw_slave.sv
module spi_rw_slave
(
  input  logic clk,
  input  logic reset,
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  spi_bus_if.slave bus
);
  import spi_pkg::*;

  localparam int cnt_bits = $clog2(byte_bits);
  localparam int acnt_bits = $clog2(addr_bytes);

  typedef enum logic [1:0] {st_cmd, st_addr, st_data, st_skip} state_t;

  logic [1:0] csn_sync;  // two flop synchronizers
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic sclk_d;          // previous synced sclk
  logic sel;
  logic sclk_rise;
  logic sclk_fall;
  logic [cnt_bits-1:0] bit_cnt;
  logic [byte_bits-1:0] shift_in;
  logic [byte_bits-1:0] shift_out;
  logic byte_done;       // shift_in holds a full byte
  logic load_pending;    // rd seen, load on next falling sclk
  logic is_read;
  logic [acnt_bits-1:0] byte_cnt; // address bytes received
  state_t state;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      csn_sync <= '1; // deselected
      sclk_sync <= '0;
      mosi_sync <= '0;
      sclk_d <= 1'b0;
    end
    else
    begin
      csn_sync <= {csn_sync[0], csn};
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_d <= sclk_sync[1];
    end
  end

  assign sel = ~csn_sync[1];
  assign sclk_rise = sel & sclk_sync[1] & ~sclk_d;
  assign sclk_fall = sel & ~sclk_sync[1] & sclk_d;

  // mosi sampled on rising sclk
  always_ff @(posedge clk)
  begin
    if (reset || !sel)
    begin
      bit_cnt <= '0; // realign on every select
      byte_done <= 1'b0;
    end
    else
    begin
      byte_done <= sclk_rise && (bit_cnt == cnt_bits'(byte_bits - 1));
      if (sclk_rise)
      begin
        shift_in <= {shift_in[byte_bits-2:0], mosi_sync[1]};
        bit_cnt <= bit_cnt + 1'b1; // wraps at byte end
      end
    end
  end

  // command, address and data phases
  always_ff @(posedge clk)
  begin
    bus.rd <= 1'b0;
    bus.wr <= 1'b0;
    if (reset || !sel)
    begin
      state <= st_cmd;
      byte_cnt <= '0;
      is_read <= 1'b0;
    end
    else
    begin
      if (bus.wr)
        bus.addr <= bus.addr + 1'b1; // next write byte
      if (byte_done)
      begin
        case (state)
          st_cmd:
          begin
            if (shift_in == cmd_read || shift_in == cmd_write)
            begin
              is_read <= (shift_in == cmd_read);
              byte_cnt <= '0;
              state <= st_addr;
            end
            else
              state <= st_skip; // unknown command, wait for csn
          end
          st_addr:
          begin
            bus.addr <= {bus.addr[addr_bits-byte_bits-1:0], shift_in};
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == acnt_bits'(addr_bytes - 1))
            begin
              state <= st_data;
              bus.rd <= is_read; // prefetch first read byte
            end
          end
          st_data:
          begin
            if (is_read)
            begin
              bus.addr <= bus.addr + 1'b1; // fetch the following byte
              bus.rd <= 1'b1;
            end
            else
            begin
              bus.data_out <= shift_in;
              bus.wr <= 1'b1;
            end
          end
          default: ; // st_skip
        endcase
      end
    end
  end

  // miso changes on falling sclk, mode 0
  always_ff @(posedge clk)
  begin
    if (reset || !sel)
    begin
      shift_out <= '0; // keeps miso low when idle
      load_pending <= 1'b0;
    end
    else
    begin
      if (bus.rd)
        load_pending <= 1'b1;
      if (sclk_fall)
      begin
        if (load_pending)
        begin
          shift_out <= bus.data_in; // fetched byte, msb out first
          load_pending <= 1'b0;
        end
        else
          shift_out <= {shift_out[byte_bits-2:0], 1'b0};
      end
    end
  end

  assign miso = shift_out[byte_bits-1];

  // one strobe per byte, never both
  assert property (@(posedge clk) disable iff (reset) !(bus.rd && bus.wr));

endmodule

// File: source/byte_word_bridge.sv
module byte_word_bridge
(
  input  logic clk,
  input  logic reset,
  spi_bus_if.bridge bus,
  mem_if.bridge mem,
  output logic [spi_pkg::byte_bits-1:0] cpu_control
);
  import spi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {sel_none, sel_mem, sel_ctrl} region_t;

  logic [byte_bits-1:0] region_byte; // top address byte
  region_t region;
  region_t rd_region;                // region latched at rd
  logic rd_lo;                       // odd byte requested
  logic [byte_bits-1:0] hi_byte;     // pending even byte
  logic [mem_addr_bits-1:0] word_addr;

  assign region_byte = bus.addr[addr_bits-1 -: byte_bits];
  assign word_addr = bus.addr[mem_addr_bits:1]; // drop byte lane bit

  always_comb
  begin
    if (region_byte == region_mem)
      region = sel_mem;
    else if (region_byte == region_ctrl)
      region = sel_ctrl;
    else
      region = sel_none;
  end

  // strobes and control register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mem.req <= 1'b0;
      mem.we <= 1'b0;
      cpu_control <= '0;
      rd_region <= sel_none;
    end
    else
    begin
      mem.req <= 1'b0;
      mem.we <= 1'b0;
      if (bus.wr && region == sel_ctrl)
        cpu_control <= bus.data_out;
      if (bus.wr && region == sel_mem && bus.addr[0])
      begin
        mem.req <= 1'b1; // odd byte completes the word
        mem.we <= 1'b1;
      end
      if (bus.rd)
      begin
        rd_region <= region;
        if (region == sel_mem)
          mem.req <= 1'b1; // whole word read, lane picked below
      end
    end
  end

  // byte packing and request address
  always_ff @(posedge clk)
  begin
    if (bus.wr && region == sel_mem)
    begin
      if (!bus.addr[0])
        hi_byte <= bus.data_out; // even byte waits for its partner
      else
        mem.wdata <= {hi_byte, bus.data_out};
    end
    if (bus.wr || bus.rd)
      mem.addr <= word_addr;
    if (bus.rd)
      rd_lo <= bus.addr[0];
  end

  // read byte select, settles once rdata is valid
  always_comb
  begin
    case (rd_region)
      sel_mem: bus.data_in = rd_lo ? mem.rdata[byte_bits-1:0]
                                   : mem.rdata[word_bits-1 -: byte_bits];
      sel_ctrl: bus.data_in = cpu_control;
      default: bus.data_in = '0; // unmapped reads as zero
    endcase
  end

  // word write carries the odd byte and its word address
  assert property (@(posedge clk) disable iff (reset)
    mem.req && mem.we |-> $past(bus.wr && bus.addr[0]) && mem.addr == $past(word_addr)
      && mem.wdata[byte_bits-1:0] == $past(bus.data_out));

endmodule

// File: source/word_ram.sv
module word_ram
(
  input logic clk,
  mem_if.ram mem
);
  import mem_pkg::*;

  logic [word_bits-1:0] ram [mem_depth];
  logic [mem_addr_bits-1:0] addr_q; // registered read address
  logic rd_q;                       // read in flight

  // the pipeline below is two stages deep
  if (read_latency != 2)
  begin : g_latency_check
    $error("word_ram supports a read latency of 2 only");
  end

  // write lands at the edge that sees req
  always_ff @(posedge clk)
  begin
    if (mem.req && mem.we)
      ram[mem.addr] <= mem.wdata;
  end

  // stage 1 address, stage 2 data
  always_ff @(posedge clk)
  begin
    rd_q <= mem.req && !mem.we;
    if (mem.req && !mem.we)
      addr_q <= mem.addr;
    if (rd_q)
      mem.rdata <= ram[addr_q]; // held across writes
  end

  // bridge must present a known address with every request
  assert property (@(posedge clk) mem.req |-> !$isunknown({mem.we, mem.addr}));

endmodule

// File: source/spi_loader_top.sv
module spi_loader_top
(
  input  logic clk,
  input  logic reset,
  input  logic spi_csn,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic spi_miso,
  output logic [spi_pkg::byte_bits-1:0] cpu_control
);

  spi_bus_if spi_bus (); // byte strobes, slave to bridge
  mem_if mem_bus ();     // word requests, bridge to ram

  // spi pins in, byte strobes out
  spi_rw_slave spi_rw_slave_inst
  (
    .clk(clk),
    .reset(reset),
    .csn(spi_csn),
    .sclk(spi_sclk),
    .mosi(spi_mosi),
    .miso(spi_miso),
    .bus(spi_bus.slave)
  );

  // byte pairs to words, control register
  byte_word_bridge byte_word_bridge_inst
  (
    .clk(clk),
    .reset(reset),
    .bus(spi_bus.bridge),
    .mem(mem_bus.bridge),
    .cpu_control(cpu_control)
  );

  // stands in for the sdram cpu port
  word_ram word_ram_inst
  (
    .clk(clk),
    .mem(mem_bus.ram)
  );

endmodule

// File: test/spi_host_tasks.svh
// spi mode 0 host, msb first, sclk idles low
localparam int half_clks = 8; // sclk half period in clk cycles

// every task leaves the pins 1 ns after a rising clk edge
task automatic sclk_half_period();
  repeat (half_clks) @(posedge clk);
  #1;
endtask

// one full byte, miso sampled as sclk rises
task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--)
  begin
    spi_mosi = tx[i]; // set up while sclk low
    sclk_half_period();
    spi_sclk = 1'b1;
    rx[i] = spi_miso;
    sclk_half_period();
    spi_sclk = 1'b0; // slave shifts miso here
  end
endtask

// select, command byte, then the address msb byte first
task automatic start_frame(input logic [7:0] cmd, input logic [31:0] addr);
  logic [7:0] rx;
  spi_csn = 1'b0;
  sclk_half_period();
  shift_byte(cmd, rx);
  for (int k = addr_bytes - 1; k >= 0; k--)
    shift_byte(addr[k*8 +: 8], rx);
endtask

task automatic finish_frame();
  sclk_half_period();
  spi_csn = 1'b1;
  spi_mosi = 1'b0;
  repeat (4) sclk_half_period(); // let the last word write land
endtask

// tx_buf[0 .. count-1] from addr upward
task automatic send_write(input logic [31:0] addr, input int count);
  logic [7:0] rx;
  start_frame(cmd_write, addr);
  for (int i = 0; i < count; i++)
    shift_byte(tx_buf[i], rx);
  finish_frame();
endtask

// dummy bytes out, rx_buf[0 .. count-1] in
task automatic send_read(input logic [31:0] addr, input int count);
  logic [7:0] rx;
  start_frame(cmd_read, addr);
  for (int i = 0; i < count; i++)
  begin
    shift_byte(8'h00, rx);
    rx_buf[i] = rx;
  end
  finish_frame();
endtask

// File: test/tb_spi_loader.sv
module tb_spi_loader;
  timeunit 1ns;
  timeprecision 100ps;
  import spi_pkg::*;
  import mem_pkg::*;

  logic clk;
  logic reset;
  logic spi_csn;
  logic spi_sclk;
  logic spi_mosi;
  logic spi_miso;
  logic [byte_bits-1:0] cpu_control;

  logic [7:0] tx_buf [64]; // bytes for the next write burst
  logic [7:0] rx_buf [64]; // bytes from the last read burst
  logic [word_bits-1:0] model_mem [mem_depth]; // expected word contents
  logic [7:0] model_hi;    // even byte waiting for its odd partner
  logic [7:0] model_ctrl;

  spi_loader_top spi_loader_top_inst
  (
    .clk(clk),
    .reset(reset),
    .spi_csn(spi_csn),
    .spi_sclk(spi_sclk),
    .spi_mosi(spi_mosi),
    .spi_miso(spi_miso),
    .cpu_control(cpu_control)
  );

  always #20 clk = ~clk; // 40 ns period

  `include "spi_host_tasks.svh"

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_byte(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
    if (actual !== expected)
    begin
      $display("mismatch %s: actual 0x%02h expected 0x%02h", name, actual, expected);
      abort_run();
    end
  endtask

  // even address is the high byte, a word is written by the odd byte
  task automatic model_store(input logic [31:0] addr, input logic [7:0] b);
    if (addr[31:24] == region_mem)
    begin
      if (!addr[0])
        model_hi = b;
      else
        model_mem[addr[mem_addr_bits:1]] = {model_hi, b};
    end
    else if (addr[31:24] == region_ctrl)
      model_ctrl = b;
  endtask

  function automatic logic [7:0] expected_byte(input logic [31:0] addr);
    logic [word_bits-1:0] w;
    w = model_mem[addr[mem_addr_bits:1]];
    if (addr[31:24] == region_mem)
      return addr[0] ? w[7:0] : w[15:8];
    else if (addr[31:24] == region_ctrl)
      return model_ctrl;
    return 8'h00; // unmapped
  endfunction

  task automatic write_bytes(input logic [31:0] addr, input int count);
    send_write(addr, count);
    for (int i = 0; i < count; i++)
      model_store(addr + 32'(i), tx_buf[i]);
  endtask

  task automatic verify_readback(input logic [31:0] addr, input int count);
    send_read(addr, count);
    for (int i = 0; i < count; i++)
      compare_byte($sformatf("spi_miso byte at 0x%08h", addr + 32'(i)), rx_buf[i],
                   expected_byte(addr + 32'(i)));
  endtask

  task automatic wait_control(input logic [7:0] expected);
    int cycles;
    cycles = 0;
    while (cpu_control !== expected && cycles < 32)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cpu_control !== expected)
    begin
      $display("cpu_control did not take the written byte within 32 cycles");
      abort_run();
    end
  endtask

  // sclk and mosi toggle while deselected, miso must stay low
  task automatic check_miso_idle();
    logic [7:0] rx;
    shift_byte(8'hA5, rx);
    compare_byte("spi_miso while csn high", rx, 8'h00);
    compare_byte("spi_miso", 8'(spi_miso), 8'h00);
  endtask

  task automatic check_reset();
    compare_byte("cpu_control", cpu_control, 8'h00);
    check_miso_idle();
  endtask

  task automatic burst_readback();
    logic [31:0] base;
    base = 32'($urandom) & 32'h0000_07FE; // even, region_mem
    for (int i = 0; i < 32; i++)
      tx_buf[i] = 8'($urandom);
    write_bytes(base, 32);
    verify_readback(base, 32);
  endtask

  task automatic lone_even_byte();
    tx_buf[0] = 8'h3C;
    tx_buf[1] = 8'hC3;
    write_bytes(32'h0000_0040, 2);
    tx_buf[0] = 8'h99; // no partner, no word write
    write_bytes(32'h0000_0040, 1);
    verify_readback(32'h0000_0040, 2);
  endtask

  task automatic control_register();
    tx_buf[0] = 8'hA7;
    write_bytes(32'hFF00_0000, 1);
    wait_control(model_ctrl);
    verify_readback(32'hFF00_0000, 1);
    check_miso_idle(); // prefetch left a byte with msb set in the shifter
  endtask

  // 0x12000000 aliases word 0 but must not reach it
  task automatic unmapped_region();
    tx_buf[0] = 8'h11;
    tx_buf[1] = 8'h22;
    write_bytes(32'h0000_0000, 2);
    tx_buf[0] = 8'hEE;
    tx_buf[1] = 8'hDD;
    write_bytes(32'h1200_0000, 2);
    compare_byte("cpu_control", cpu_control, model_ctrl);
    verify_readback(32'h1200_0000, 2);
    verify_readback(32'h0000_0000, 2);
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    spi_csn = 1'b1; // deselected
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    model_ctrl = 8'h00;
    void'($urandom(75));
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset();
    burst_readback();
    lone_even_byte();
    control_register();
    unmapped_region();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: tb.f
source/spi_pkg.sv
source/mem_pkg.sv
source/spi_bus_if.sv
source/mem_if.sv
source/spi_rw_slave.sv
source/byte_word_bridge.sv
source/word_ram.sv
source/spi_loader_top.sv
+incdir+test
test/tb_spi_loader.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the spi loader testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_spi_loader -f tb.f -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_spi_loader
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

echo "simulation exited cleanly"
exit 0
